/* common/ctrl_pkg.sv */
////////////////////
// Control register package
// Settings bus widths, register addresses and decode opcodes
////////////////////

package ctrl_pkg;

   ////////////////////
   // Settings bus
   ////////////////////

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   ////////////////////
   // Board pin groups
   ////////////////////

   // clock_ready, clk_en[1:0], clk_sel[1:0]
   localparam int CLK_OUT_W = 5;
   // enable, prbsen, loopen, rx_en
   localparam int SER_OUT_W = 4;
   // oe_a, on_a, oe_b, on_b
   localparam int ADC_OUT_W = 4;
   localparam int LED_W     = 8;

   ////////////////////
   // Register map
   ////////////////////

   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLK     = 8'd0,
      SR_SER     = 8'd1,
      SR_ADC     = 8'd2,
      SR_LED     = 8'd3,
      SR_PHY     = 8'd4,
      SR_DEBUG   = 8'd5,
      SR_ICACHE  = 8'd7,
      SR_LED_SRC = 8'd8
   } setting_addr_e;

   // Result of classifying one settings strobe
   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_WRITE  = 2'd1,
      OP_IGNORE = 2'd2
   } set_op_e;

endpackage

/* common/ctrl_regs_if.sv */
////////////////////
// Register contents from the setting bank to the output stage
////////////////////

`timescale 1ns/1ps

interface ctrl_regs_if import ctrl_pkg::*; ();

   logic [CLK_OUT_W-1:0]  clk_reg;
   logic [SER_OUT_W-1:0]  ser_reg;
   logic [ADC_OUT_W-1:0]  adc_reg;
   logic [LED_W-1:0]      led_sw;
   // Per bit, 1 selects hardware status
   logic [LED_W-1:0]      led_src;
   logic                  phy_reset;
   logic                  debug_sel;
   logic [SET_DATA_W-1:0] icache_reg;

   modport bank (
      output clk_reg, ser_reg, adc_reg, led_sw, led_src,
      output phy_reset, debug_sel, icache_reg
   );

   modport out (
      input clk_reg, ser_reg, adc_reg, led_sw, led_src,
      input phy_reset, debug_sel, icache_reg
   );

endinterface

/* src/set_decode.sv */
////////////////////
// Settings write decode
// Registers a strobe and classifies its address
////////////////////

`timescale 1ns/1ps

module set_decode import ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  arst_n_i,
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   output set_op_e               op_o,
   output setting_addr_e         sel_o,
   output logic [SET_DATA_W-1:0] data_o
);

   logic addr_known;

   // Address lands on one of the assigned registers
   always_comb begin
      case (set_addr_i)
         SR_CLK,
         SR_SER,
         SR_ADC,
         SR_LED,
         SR_PHY,
         SR_DEBUG,
         SR_ICACHE,
         SR_LED_SRC: addr_known = 1'b1;
         default:    addr_known = 1'b0;
      endcase
   end

   ////////////////////
   // Decode register
   ////////////////////

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         op_o   <= OP_NONE;
         sel_o  <= SR_CLK;
         data_o <= '0;
      end else if (set_stb_i) begin
         op_o   <= addr_known ? OP_WRITE : OP_IGNORE;
         sel_o  <= setting_addr_e'(set_addr_i);
         data_o <= set_data_i;
      end else begin
         // Address and data hold, only the opcode drops
         op_o <= OP_NONE;
      end
   end

endmodule

/* src/setting_bank.sv */
////////////////////
// Setting register bank
// Loads decoded writes and pulses the cache flush
////////////////////

`timescale 1ns/1ps

module setting_bank import ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  arst_n_i,
   input  set_op_e               op_i,
   input  setting_addr_e         sel_i,
   input  logic [SET_DATA_W-1:0] data_i,
   ctrl_regs_if.bank             regs,
   output logic                  flush_icache_o
);

   logic write_en;

   assign write_en = (op_i == OP_WRITE);

   ////////////////////
   // Register bank
   ////////////////////

   // Each register keeps only the low bits of its field
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         regs.clk_reg    <= '0;
         regs.ser_reg    <= '0;
         regs.adc_reg    <= '0;
         regs.led_sw     <= '0;
         regs.led_src    <= '0;
         regs.phy_reset  <= 1'b0;
         regs.debug_sel  <= 1'b0;
         regs.icache_reg <= '0;
      end else if (write_en) begin
         case (sel_i)
            SR_CLK:     regs.clk_reg    <= data_i[CLK_OUT_W-1:0];
            SR_SER:     regs.ser_reg    <= data_i[SER_OUT_W-1:0];
            SR_ADC:     regs.adc_reg    <= data_i[ADC_OUT_W-1:0];
            SR_LED:     regs.led_sw     <= data_i[LED_W-1:0];
            SR_PHY:     regs.phy_reset  <= data_i[0];
            SR_DEBUG:   regs.debug_sel  <= data_i[0];
            SR_ICACHE:  regs.icache_reg <= data_i;
            SR_LED_SRC: regs.led_src    <= data_i[LED_W-1:0];
            default: begin
            end
         endcase
      end
   end

   ////////////////////
   // Flush pulse
   ////////////////////

   // One cycle per write to the cache register, even with the same value
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flush_icache_o <= 1'b0;
      end else begin
         flush_icache_o <= write_en && (sel_i == SR_ICACHE);
      end
   end

endmodule

/* src/ctrl_outputs.sv */
////////////////////
// Output stage
// Board pins, LED mux and register readback
////////////////////

`timescale 1ns/1ps

module ctrl_outputs import ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  arst_n_i,
   ctrl_regs_if.out              regs,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  rb_stb_i,
   input  logic [SET_ADDR_W-1:0] rb_addr_i,
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,
   output logic                  phy_reset_n_o,
   output logic [LED_W-1:0]      leds_o,
   output logic                  debug_sel_o,
   output logic [SET_DATA_W-1:0] rb_data_o,
   output logic                  rb_ack_o
);

   logic [LED_W-1:0]      led_hw;
   logic [SET_DATA_W-1:0] rb_word;

   // Pin groups, high bit first
   assign {clock_ready_o, clk_en_o, clk_sel_o} = regs.clk_reg;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = regs.ser_reg;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = regs.adc_reg;
   assign phy_reset_n_o = ~regs.phy_reset;
   assign debug_sel_o   = regs.debug_sel;

   ////////////////////
   // LEDs
   ////////////////////

   assign led_hw = {{(LED_W-2){1'b0}}, clk_status_i, serdes_link_up_i};
   assign leds_o = (regs.led_src & led_hw) | (~regs.led_src & regs.led_sw);

   ////////////////////
   // Readback
   ////////////////////

   always_comb begin
      case (rb_addr_i)
         SR_CLK:     rb_word = SET_DATA_W'(regs.clk_reg);
         SR_SER:     rb_word = SET_DATA_W'(regs.ser_reg);
         SR_ADC:     rb_word = SET_DATA_W'(regs.adc_reg);
         SR_LED:     rb_word = SET_DATA_W'(regs.led_sw);
         SR_PHY:     rb_word = SET_DATA_W'(regs.phy_reset);
         SR_DEBUG:   rb_word = SET_DATA_W'(regs.debug_sel);
         SR_ICACHE:  rb_word = regs.icache_reg;
         SR_LED_SRC: rb_word = SET_DATA_W'(regs.led_src);
         default:    rb_word = '0;
      endcase
   end

   // Ack and data valid for the one cycle after the strobe
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rb_ack_o  <= 1'b0;
         rb_data_o <= '0;
      end else begin
         rb_ack_o  <= rb_stb_i;
         rb_data_o <= rb_stb_i ? rb_word : '0;
      end
   end

endmodule

/* src/ctrl_core.sv */
////////////////////
// Control register core
// Settings decode, register bank and output stage
////////////////////

`timescale 1ns/1ps

module ctrl_core import ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  arst_n_i,
   // Settings write
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   // Readback
   input  logic                  rb_stb_i,
   input  logic [SET_ADDR_W-1:0] rb_addr_i,
   output logic [SET_DATA_W-1:0] rb_data_o,
   output logic                  rb_ack_o,
   // Hardware status
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   // Board control pins
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,
   output logic                  phy_reset_n_o,
   output logic [LED_W-1:0]      leds_o,
   output logic                  debug_sel_o,
   output logic                  flush_icache_o
);

   set_op_e               dec_op;
   setting_addr_e         dec_sel;
   logic [SET_DATA_W-1:0] dec_data;

   ctrl_regs_if regs_if ();

   set_decode set_decode_inst (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .op_o       (dec_op),
      .sel_o      (dec_sel),
      .data_o     (dec_data)
   );

   setting_bank setting_bank_inst (
      .dsp_clk        (dsp_clk),
      .arst_n_i       (arst_n_i),
      .op_i           (dec_op),
      .sel_i          (dec_sel),
      .data_i         (dec_data),
      .regs           (regs_if.bank),
      .flush_icache_o (flush_icache_o)
   );

   ctrl_outputs ctrl_outputs_inst (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n_i),
      .regs             (regs_if.out),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .rb_stb_i         (rb_stb_i),
      .rb_addr_i        (rb_addr_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o),
      .debug_sel_o      (debug_sel_o),
      .rb_data_o        (rb_data_o),
      .rb_ack_o         (rb_ack_o)
   );

endmodule

/* tb/ctrl_core_assertions.sv */
////////////////////
// Protocol checks bound to the control core
////////////////////

`timescale 1ns/1ps

module ctrl_core_assertions (
   input logic dsp_clk,
   input logic arst_n_i,
   input logic rb_stb_i,
   input logic rb_ack_i,
   input logic flush_icache_i,
   input logic phy_reset_n_i
);

   // Ack exactly one cycle after each strobe
   ack_after_stb: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      rb_stb_i |=> rb_ack_i)
      else $error("rb_ack_o missing one cycle after rb_stb_i");

   ack_only_after_stb: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      !rb_stb_i |=> !rb_ack_i)
      else $error("rb_ack_o high without a preceding rb_stb_i");

   flush_single_cycle: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      flush_icache_i |=> !flush_icache_i)
      else $error("flush_icache_o high for two cycles");

   // PHY held out of reset once the core leaves reset
   phy_after_reset: assert property (@(posedge dsp_clk) $rose(arst_n_i) |-> phy_reset_n_i)
      else $error("phy_reset_n_o low in the cycle after reset");

endmodule

bind ctrl_core ctrl_core_assertions ctrl_core_assertions_inst (
   .dsp_clk        (dsp_clk),
   .arst_n_i       (arst_n_i),
   .rb_stb_i       (rb_stb_i),
   .rb_ack_i       (rb_ack_o),
   .flush_icache_i (flush_icache_o),
   .phy_reset_n_i  (phy_reset_n_o)
);

/* tb/ctrl_core_tb.sv */
////////////////////
// Control core testbench
// Replays the trace file against the DUT and checks every result
////////////////////

`timescale 1ns/1ps

module ctrl_core_tb import ctrl_pkg::*; ();

   // Each trace record holds kind, address, data and expected value as hex words
   localparam int REC_W       = 4;
   localparam int MAX_OPS     = 64;
   localparam int TRACE_WORDS = MAX_OPS * REC_W;
   localparam int KIND_WRITE  = 32'h1;
   localparam int KIND_READ   = 32'h2;
   localparam int KIND_STATUS = 32'h3;
   localparam int KIND_PINS   = 32'h4;
   localparam int KIND_END    = 32'hF;
   localparam int ACK_WAIT    = 4;

   logic                  dsp_clk;
   logic                  arst_n_i;
   logic                  set_stb_i;
   logic [SET_ADDR_W-1:0] set_addr_i;
   logic [SET_DATA_W-1:0] set_data_i;
   logic                  rb_stb_i;
   logic [SET_ADDR_W-1:0] rb_addr_i;
   logic [SET_DATA_W-1:0] rb_data_o;
   logic                  rb_ack_o;
   logic                  clk_status_i;
   logic                  serdes_link_up_i;
   logic                  clock_ready_o;
   logic [1:0]            clk_en_o;
   logic [1:0]            clk_sel_o;
   logic                  ser_enable_o;
   logic                  ser_prbsen_o;
   logic                  ser_loopen_o;
   logic                  ser_rx_en_o;
   logic                  adc_oe_a_o;
   logic                  adc_on_a_o;
   logic                  adc_oe_b_o;
   logic                  adc_on_b_o;
   logic                  phy_reset_n_o;
   logic [LED_W-1:0]      leds_o;
   logic                  debug_sel_o;
   logic                  flush_icache_o;

   logic [31:0] trace_mem [0:TRACE_WORDS-1];
   int          num_ops;
   int          timeout_limit;
   int          cycle_cnt = 0;
   logic        flush_wr_d1;
   logic        flush_exp;

   ctrl_core ctrl_core_inst (.*);

   always #5 dsp_clk = ~dsp_clk;

   task automatic fail_run();
      $display("Errors found");
      $fatal(1, "Run stopped at the first failure");
   endtask

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_word(input string name, input logic [SET_DATA_W-1:0] got,
                             input logic [SET_DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_leds(input string name, input logic [LED_W-1:0] got,
                             input logic [LED_W-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_pin(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   ////////////////////
   // Trace operations
   ////////////////////

   // One strobe cycle per write so that writes can follow back to back
   task automatic do_write(input logic [SET_ADDR_W-1:0] addr, input logic [SET_DATA_W-1:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
   endtask

   // Idle edge lets a pending write land before the read strobe
   task automatic do_read(input logic [SET_ADDR_W-1:0] addr, input logic [SET_DATA_W-1:0] exp);
      int waited;
      waited = 0;
      @(posedge dsp_clk);
      set_stb_i <= 1'b0;
      @(posedge dsp_clk);
      rb_stb_i  <= 1'b1;
      rb_addr_i <= addr;
      @(posedge dsp_clk);
      rb_stb_i <= 1'b0;
      @(negedge dsp_clk);
      while (!rb_ack_o && waited < ACK_WAIT) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (!rb_ack_o) begin
         $display("No readback ack for address 0x%h", addr);
         fail_run();
      end else begin
         check_word("rb_data_o", rb_data_o, exp);
      end
   endtask

   task automatic do_status(input logic clk_status, input logic link_up,
                            input logic [LED_W-1:0] exp);
      @(posedge dsp_clk);
      set_stb_i        <= 1'b0;
      clk_status_i     <= clk_status;
      serdes_link_up_i <= link_up;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_leds("leds_o", leds_o, exp);
   endtask

   // Pin word from the high bit down holds clk group, SERDES, ADC, phy_reset_n and debug_sel
   task automatic do_pins(input logic [14:0] exp);
      @(posedge dsp_clk);
      set_stb_i <= 1'b0;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_pin("clock_ready_o", clock_ready_o, exp[14]);
      check_pin("clk_en_o[1]", clk_en_o[1], exp[13]);
      check_pin("clk_en_o[0]", clk_en_o[0], exp[12]);
      check_pin("clk_sel_o[1]", clk_sel_o[1], exp[11]);
      check_pin("clk_sel_o[0]", clk_sel_o[0], exp[10]);
      check_pin("ser_enable_o", ser_enable_o, exp[9]);
      check_pin("ser_prbsen_o", ser_prbsen_o, exp[8]);
      check_pin("ser_loopen_o", ser_loopen_o, exp[7]);
      check_pin("ser_rx_en_o", ser_rx_en_o, exp[6]);
      check_pin("adc_oe_a_o", adc_oe_a_o, exp[5]);
      check_pin("adc_on_a_o", adc_on_a_o, exp[4]);
      check_pin("adc_oe_b_o", adc_oe_b_o, exp[3]);
      check_pin("adc_on_b_o", adc_on_b_o, exp[2]);
      check_pin("phy_reset_n_o", phy_reset_n_o, exp[1]);
      check_pin("debug_sel_o", debug_sel_o, exp[0]);
   endtask

   task automatic run_op(input int idx);
      logic [7:0]  base;
      logic [31:0] kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expv;
      base = 8'(idx * REC_W);
      kind = trace_mem[base];
      addr = trace_mem[base + 8'd1];
      data = trace_mem[base + 8'd2];
      expv = trace_mem[base + 8'd3];
      case (kind)
         KIND_WRITE:  do_write(addr[SET_ADDR_W-1:0], data);
         KIND_READ:   do_read(addr[SET_ADDR_W-1:0], expv);
         KIND_STATUS: do_status(data[1], data[0], expv[LED_W-1:0]);
         KIND_PINS:   do_pins(expv[14:0]);
         default: begin
            $display("Unknown operation kind 0x%h in trace record %0d", kind, idx);
            fail_run();
         end
      endcase
   endtask

   function automatic int count_ops();
      int n;
      n = 0;
      while (n < MAX_OPS && trace_mem[8'(n * REC_W)] != KIND_END) begin
         n++;
      end
      return n;
   endfunction

   ////////////////////
   // Flush pulse monitor
   ////////////////////

   // Pulse expected in the cycle after edge N+1 for a cache write sampled at N
   always @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flush_wr_d1 <= 1'b0;
         flush_exp   <= 1'b0;
      end else begin
         flush_wr_d1 <= set_stb_i && (set_addr_i == SR_ICACHE);
         flush_exp   <= flush_wr_d1;
      end
   end

   always @(negedge dsp_clk) begin
      if (arst_n_i && flush_icache_o !== flush_exp) begin
         if (flush_exp) begin
            $display("Flush pulse missing after a write to the cache register");
         end else begin
            $display("Unexpected flush pulse on flush_icache_o");
         end
         fail_run();
      end
   end

   always @(posedge dsp_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) begin
         $display("Timeout, run still busy after %0d cycles", cycle_cnt);
         fail_run();
      end
   end

   initial begin
      dsp_clk          = 1'b0;
      arst_n_i         <= 1'b0;
      set_stb_i        <= 1'b0;
      set_addr_i       <= '0;
      set_data_i       <= '0;
      rb_stb_i         <= 1'b0;
      rb_addr_i        <= '0;
      clk_status_i     <= 1'b0;
      serdes_link_up_i <= 1'b0;
      $readmemh("tb/ctrl_trace.txt", trace_mem);
      num_ops = count_ops();
      timeout_limit = 10 * num_ops + 20;
      if (num_ops == MAX_OPS) begin
         $display("Trace file has no end record");
         fail_run();
      end else begin
         repeat (2) @(posedge dsp_clk);
         arst_n_i <= 1'b1;
         for (int i = 0; i < num_ops; i++) begin
            run_op(i);
         end
         @(posedge dsp_clk);
         set_stb_i <= 1'b0;
         // Drain so a late flush pulse is still seen
         repeat (3) @(posedge dsp_clk);
         $display("No errors");
         $finish;
      end
   end

endmodule

/* tb/ctrl_trace.txt */
// Columns: kind addr data expected, all hex
// Kinds: 1 write, 2 read, 3 status (data bit 1 clk_status, bit 0 link up), 4 pins, F end
4 00 00000000 00000002
2 00 00000000 00000000
2 01 00000000 00000000
2 02 00000000 00000000
2 03 00000000 00000000
2 04 00000000 00000000
2 05 00000000 00000000
2 07 00000000 00000000
2 08 00000000 00000000
3 00 00000000 00000000
1 00 ffffffea 00000000
1 01 00000005 00000000
1 02 0000000c 00000000
1 04 00000003 00000000
1 05 00000001 00000000
4 00 00000000 00002971
2 00 00000000 0000000a
2 01 00000000 00000005
2 02 00000000 0000000c
2 04 00000000 00000001
2 05 00000000 00000001
1 06 12345678 00000000
1 09 ffffffff 00000000
2 06 00000000 00000000
2 09 00000000 00000000
2 00 00000000 0000000a
1 03 000000a5 00000000
1 08 00000003 00000000
3 00 00000002 000000a6
3 00 00000001 000000a5
1 07 deadbeef 00000000
1 03 0000003c 00000000
3 00 00000003 0000003f
2 07 00000000 deadbeef
2 08 00000000 00000003
1 04 00000000 00000000
4 00 00000000 00002973
F 00 00000000 00000000

/* files.f */
common/ctrl_pkg.sv
common/ctrl_regs_if.sv
src/set_decode.sv
src/setting_bank.sv
src/ctrl_outputs.sv
src/ctrl_core.sv
tb/ctrl_core_assertions.sv
tb/ctrl_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module ctrl_core_tb -f files.f -o ctrl_core_sim

output=$(./obj_dir/ctrl_core_sim 2>&1 || true)
echo "$output"

if grep -qx "No errors" <<< "$output"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
